//--- vdp_lite.f
logic/video_timing_pkg.sv
logic/vdp_regs_pkg.sv
logic/vga_timing.sv
logic/host_registers.sv
logic/vram_write_port.sv
logic/palette_output.sv
logic/vdp_lite.sv
sim/vdp_lite_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := vdp_lite_tb
FILELIST  := vdp_lite.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --timescale 1ns/1ps -j 0

BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/vdp_lite_tb.sv
// testbench for the video display processor top level
// directed tests of raster timing, VRAM writes, host_ready, palette output and raster target
// typed compare tasks and a cycle-count timeout

module vdp_lite_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int frame_cycles = video_timing_pkg::h_total * video_timing_pkg::v_total;
    // timing needs up to two frames, the raster target one more
    localparam int timeout_cycles = 3 * frame_cycles + (3 * frame_cycles) / 10;
    localparam int target_x_value = 300;
    localparam int target_y_value = 2;

    logic clk;
    logic rst_n;
    logic [15:0] host_address;
    vdp_regs_pkg::host_data_t host_write_data;
    logic host_write_en;
    logic host_read_en;
    vdp_regs_pkg::host_data_t host_read_data;
    logic host_ready;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic vga_hsync;
    logic vga_vsync;
    logic active_display;
    logic hsync;
    logic vsync;
    logic frame_ended;
    logic active_frame_ended;
    logic target_raster_hit;
    vdp_regs_pkg::vram_word_addr_t vram_address_even;
    vdp_regs_pkg::vram_word_addr_t vram_address_odd;
    vdp_regs_pkg::vram_data_t vram_read_data_even;
    vdp_regs_pkg::vram_data_t vram_read_data_odd;
    vdp_regs_pkg::vram_data_t vram_write_data_even;
    vdp_regs_pkg::vram_data_t vram_write_data_odd;
    logic vram_we_even;
    logic vram_we_odd;

    // reference raster position and the active flag two cycles back
    int model_x;
    int model_y;
    logic active_d1;
    logic active_d2;
    int cycle_count;

    vdp_lite vdp_lite_inst (
        .clk(clk),
        .rst_n(rst_n),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .r(r),
        .g(g),
        .b(b),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .active_display(active_display),
        .hsync(hsync),
        .vsync(vsync),
        .frame_ended(frame_ended),
        .active_frame_ended(active_frame_ended),
        .target_raster_hit(target_raster_hit),
        .vram_address_even(vram_address_even),
        .vram_we_even(vram_we_even),
        .vram_read_data_even(vram_read_data_even),
        .vram_write_data_even(vram_write_data_even),
        .vram_address_odd(vram_address_odd),
        .vram_we_odd(vram_we_odd),
        .vram_read_data_odd(vram_read_data_odd),
        .vram_write_data_odd(vram_write_data_odd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic is_active_position(int x, int y);
        return (x >= video_timing_pkg::h_offscreen) && (y < video_timing_pkg::v_active);
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            model_x <= 0;
            model_y <= 0;
            active_d1 <= 1'b0;
            active_d2 <= 1'b0;
        end else begin
            if (model_x == video_timing_pkg::h_total - 1) begin
                model_x <= 0;
                model_y <= (model_y == video_timing_pkg::v_total - 1) ? 0 : model_y + 1;
            end else begin
                model_x <= model_x + 1;
            end
            active_d1 <= is_active_position(model_x, model_y);
            active_d2 <= active_d1;
        end
    end

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            stop_with_failure("timeout, the tests did not finish in time");
        end
    end

    task automatic check_flag(string name, logic got, logic expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_count(string name, int got, int expected);
        if (got != expected) begin
            stop_with_failure($sformatf("Error: %s got %0h expected %0h", name, got, expected));
        end
    endtask

    task automatic check_color(string name, vdp_regs_pkg::color_t got,
                               vdp_regs_pkg::color_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_raster(string name, video_timing_pkg::raster_y_t got,
                                video_timing_pkg::raster_y_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_vram(string port, vdp_regs_pkg::vram_word_addr_t got_address,
                              vdp_regs_pkg::vram_word_addr_t expected_address,
                              vdp_regs_pkg::vram_data_t got_data,
                              vdp_regs_pkg::vram_data_t expected_data);
        if (got_address !== expected_address) begin
            stop_with_failure($sformatf("Error: vram_address_%s got %h expected %h",
                                        port, got_address, expected_address));
        end
        if (got_data !== expected_data) begin
            stop_with_failure($sformatf("Error: vram_write_data_%s got %h expected %h",
                                        port, got_data, expected_data));
        end
    endtask

    // sample point sits 2 ns after the edge, where inputs are also driven
    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_register(vdp_regs_pkg::reg_addr_t address,
                                  vdp_regs_pkg::host_data_t data);
        while (!host_ready) begin
            wait_cycle();
        end
        host_address = {10'd0, address};
        host_write_data = data;
        host_write_en = 1'b1;
        wait_cycle();
        host_write_en = 1'b0;
    endtask

    task automatic wait_for_active_line();
        while (!(model_x == 0 && model_y < video_timing_pkg::v_active - 2)) begin
            wait_cycle();
        end
    endtask

    // one write enable pulse, on the port picked by the byte address
    task automatic check_vram_pulse(vdp_regs_pkg::host_data_t data, int byte_address);
        logic odd_port;
        vdp_regs_pkg::vram_word_addr_t word_address;
        odd_port = (byte_address % 2) == 1;
        word_address = vdp_regs_pkg::vram_word_addr_t'(byte_address / 2);
        check_flag("vram_we_even", vram_we_even, !odd_port);
        check_flag("vram_we_odd", vram_we_odd, odd_port);
        if (odd_port) begin
            check_vram("odd", vram_address_odd, word_address, vram_write_data_odd, data);
        end else begin
            check_vram("even", vram_address_even, word_address, vram_write_data_even, data);
        end
        check_flag("write slot phase", model_x % 8 == 0, 1'b1);
        check_flag("host_ready at write enable", host_ready, 1'b1);
    endtask

    task automatic write_vram_and_check(vdp_regs_pkg::host_data_t data, int byte_address);
        int waited;
        logic seen;
        write_register(vdp_regs_pkg::reg_vram_data, data);
        check_flag("host_ready after data write", host_ready, 1'b0);
        seen = 1'b0;
        for (waited = 0; waited < 8 && !seen; waited++) begin
            wait_cycle();
            if (vram_we_even || vram_we_odd) begin
                seen = 1'b1;
            end else begin
                check_flag("host_ready while write pending", host_ready, 1'b0);
            end
        end
        if (!seen) begin
            stop_with_failure("no VRAM write enable within 8 cycles of a data write");
        end
        check_vram_pulse(data, byte_address);
        wait_cycle();
        check_flag("vram_we_even after pulse", vram_we_even, 1'b0);
        check_flag("vram_we_odd after pulse", vram_we_odd, 1'b0);
    endtask

    task automatic test_timing();
        int cycles;
        int lines;
        int frame_ends;
        int active_in_line;
        int hsync_low;
        int vsync_low;
        logic last_of_frame;
        while (!vsync) begin
            wait_cycle();
        end
        cycles = 0;
        lines = 0;
        frame_ends = 0;
        active_in_line = 0;
        hsync_low = 0;
        vsync_low = 0;
        do begin
            wait_cycle();
            cycles++;
            active_in_line += active_display ? 1 : 0;
            hsync_low += vga_hsync ? 0 : 1;
            vsync_low += vga_vsync ? 0 : 1;
            frame_ends += active_frame_ended ? 1 : 0;
            last_of_frame = (model_x == video_timing_pkg::h_total - 1) &&
                            (model_y == video_timing_pkg::v_total - 1);
            check_flag("hsync", hsync, model_x == video_timing_pkg::h_total - 1);
            check_flag("vsync", vsync, last_of_frame);
            check_flag("frame_ended", frame_ended, last_of_frame);
            if (hsync) begin
                check_count("active cycles in line", active_in_line,
                            (lines < video_timing_pkg::v_active) ? video_timing_pkg::h_active : 0);
                check_count("vga_hsync low cycles", hsync_low, video_timing_pkg::h_sync);
                lines++;
                active_in_line = 0;
                hsync_low = 0;
            end
        end while (!vsync);
        check_count("cycles between vsync", cycles, frame_cycles);
        check_count("hsync pulses per frame", lines, video_timing_pkg::v_total);
        check_count("active_frame_ended per frame", frame_ends, 1);
        check_count("vga_vsync low cycles", vsync_low,
                    video_timing_pkg::v_sync * video_timing_pkg::h_total);
    endtask

    task automatic test_vram_writes();
        int i;
        write_register(vdp_regs_pkg::reg_vram_increment, vdp_regs_pkg::host_data_t'(1));
        write_register(vdp_regs_pkg::reg_vram_addr, vdp_regs_pkg::host_data_t'(6));
        for (i = 0; i < 4; i++) begin
            write_vram_and_check(vdp_regs_pkg::host_data_t'($urandom), 6 + i);
        end
    endtask

    // a second data write held while busy goes out exactly once
    task automatic test_held_write();
        vdp_regs_pkg::host_data_t first;
        vdp_regs_pkg::host_data_t second;
        int pulses;
        int i;
        logic holding;
        logic accept_now;
        first = vdp_regs_pkg::host_data_t'($urandom);
        second = vdp_regs_pkg::host_data_t'($urandom);
        write_register(vdp_regs_pkg::reg_vram_data, first);
        host_address = {10'd0, vdp_regs_pkg::reg_vram_data};
        host_write_data = second;
        host_write_en = 1'b1;
        holding = 1'b1;
        pulses = 0;
        for (i = 0; i < 24; i++) begin
            accept_now = holding && host_ready;
            wait_cycle();
            if (accept_now) begin
                host_write_en = 1'b0;
                holding = 1'b0;
            end
            if (vram_we_even || vram_we_odd) begin
                pulses++;
                check_vram_pulse((pulses == 1) ? first : second, 10 + pulses - 1);
            end else if (pulses < 2) begin
                check_flag("host_ready while write pending", host_ready, 1'b0);
            end
        end
        check_count("VRAM writes for two data writes", pulses, 2);
    endtask

    task automatic test_palette();
        vdp_regs_pkg::host_data_t entry0;
        vdp_regs_pkg::color_t expected;
        int i;
        entry0 = vdp_regs_pkg::host_data_t'($urandom);
        if (entry0[11:0] == 12'd0) begin
            entry0[0] = 1'b1;
        end
        wait_for_active_line();
        for (i = 0; i < 2 * video_timing_pkg::h_total; i++) begin
            check_color("rgb with layers off", {r, g, b}, '0);
            wait_cycle();
        end
        // entry 1 differs, so a missing auto-increment would overwrite entry 0
        write_register(vdp_regs_pkg::reg_palette_addr, vdp_regs_pkg::host_data_t'(0));
        write_register(vdp_regs_pkg::reg_palette_data, entry0);
        write_register(vdp_regs_pkg::reg_palette_data, entry0 ^ 16'h0fff);
        write_register(vdp_regs_pkg::reg_layer_enable, vdp_regs_pkg::host_data_t'(1));
        repeat (4) wait_cycle();
        wait_for_active_line();
        expected = entry0[11:0];
        for (i = 0; i < 2 * video_timing_pkg::h_total; i++) begin
            check_color("rgb", {r, g, b}, active_d2 ? expected : '0);
            wait_cycle();
        end
    endtask

    task automatic test_raster_target();
        int hits;
        int i;
        write_register(vdp_regs_pkg::reg_target_y, vdp_regs_pkg::host_data_t'(target_y_value));
        write_register(vdp_regs_pkg::reg_target_x, vdp_regs_pkg::host_data_t'(target_x_value));
        repeat (3) wait_cycle();
        // bit 0 set selects raster_y on the readback
        host_address = 16'd1;
        host_read_en = 1'b1;
        hits = 0;
        for (i = 0; i < frame_cycles; i++) begin
            wait_cycle();
            if (target_raster_hit) begin
                hits++;
                check_flag("hit position", (model_x == target_x_value + 1) &&
                           (model_y == target_y_value), 1'b1);
                check_raster("host_read_data", host_read_data[9:0],
                             video_timing_pkg::raster_y_t'(target_y_value));
            end
        end
        host_read_en = 1'b0;
        check_count("target_raster_hit per frame", hits, 1);
    endtask

    initial begin
        void'($urandom(32'h0371e0d1));
        cycle_count = 0;
        rst_n = 1'b0;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        vram_read_data_even = '0;
        vram_read_data_odd = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_timing();
        test_vram_writes();
        test_held_write();
        test_palette();
        test_raster_target();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- logic/vdp_lite.sv
// top level of the cut-down video display processor
// VGA timing, host registers, VRAM write port and palette output

module vdp_lite (
    input  logic clk,
    input  logic rst_n,

    // host port
    input  logic [15:0] host_address,
    input  vdp_regs_pkg::host_data_t host_write_data,
    input  logic host_write_en,
    input  logic host_read_en,
    output vdp_regs_pkg::host_data_t host_read_data,
    output logic host_ready,

    // VGA output
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic active_display,

    // single-cycle strobes
    output logic hsync,
    output logic vsync,
    output logic frame_ended,
    output logic active_frame_ended,
    output logic target_raster_hit,

    // VRAM ports, read data is not consumed without the render layers
    output vdp_regs_pkg::vram_word_addr_t vram_address_even,
    output logic vram_we_even,
    input  vdp_regs_pkg::vram_data_t vram_read_data_even,
    output vdp_regs_pkg::vram_data_t vram_write_data_even,

    output vdp_regs_pkg::vram_word_addr_t vram_address_odd,
    output logic vram_we_odd,
    input  vdp_regs_pkg::vram_data_t vram_read_data_odd,
    output vdp_regs_pkg::vram_data_t vram_write_data_odd
);

    video_timing_pkg::raster_x_t raster_x;
    video_timing_pkg::raster_y_t raster_y;

    vdp_regs_pkg::host_write_t host_write;
    vdp_regs_pkg::palette_write_t palette_write;
    vdp_regs_pkg::vram_request_t vram_request;
    vdp_regs_pkg::layer_enable_t layer_enable;
    logic vram_request_valid;
    logic vram_busy;

    // a write only counts while the port can take it
    assign host_write = {host_address[5:0], host_write_data, host_write_en && host_ready};
    assign host_ready = !vram_busy;
    assign frame_ended = vsync;

    vga_timing vga_timing_inst (
        .clk(clk),
        .rst_n(rst_n),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .active_display(active_display),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .hsync(hsync),
        .vsync(vsync),
        .active_frame_ended(active_frame_ended)
    );

    // reads are always ready, host_read_en does not change the readback
    host_registers host_registers_inst (
        .clk(clk),
        .rst_n(rst_n),
        .host_write(host_write),
        .read_select(host_address[0]),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .vram_busy(vram_busy),
        .host_read_data(host_read_data),
        .palette_write(palette_write),
        .vram_request(vram_request),
        .vram_request_valid(vram_request_valid),
        .layer_enable(layer_enable),
        .target_raster_hit(target_raster_hit)
    );

    vram_write_port vram_write_port_inst (
        .clk(clk),
        .rst_n(rst_n),
        .raster_x(raster_x),
        .request(vram_request),
        .request_valid(vram_request_valid),
        .busy(vram_busy),
        .vram_address_even(vram_address_even),
        .vram_address_odd(vram_address_odd),
        .vram_write_data_even(vram_write_data_even),
        .vram_write_data_odd(vram_write_data_odd),
        .vram_we_even(vram_we_even),
        .vram_we_odd(vram_we_odd)
    );

    palette_output palette_output_inst (
        .clk(clk),
        .rst_n(rst_n),
        .palette_write(palette_write),
        .layer_enable(layer_enable),
        .active_display(active_display),
        .r(r),
        .g(g),
        .b(b)
    );

endmodule

//--- logic/palette_output.sv
// 256-entry palette RAM written from the host registers
// backdrop colour lookup and gated, registered RGB output

module palette_output (
    input  logic clk,
    input  logic rst_n,

    input  vdp_regs_pkg::palette_write_t palette_write,
    input  vdp_regs_pkg::layer_enable_t layer_enable,
    input  logic active_display,

    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    logic [15:0] palette_ram [256];
    logic [15:0] palette_data;
    logic show_pixel;
    vdp_regs_pkg::color_t pixel_color;

    always_ff @(posedge clk) begin
        if (palette_write.enable) begin
            palette_ram[palette_write.index] <= palette_write.data;
        end
        palette_data <= palette_ram[vdp_regs_pkg::backdrop_index];
    end

    // enable condition follows the RAM read by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            show_pixel <= 1'b0;
            {r, g, b} <= '0;
        end else begin
            show_pixel <= (|layer_enable) && active_display;
            {r, g, b} <= show_pixel ? pixel_color : '0;
        end
    end

    // only the low 12 bits carry colour
    assign pixel_color = palette_data[11:0];

endmodule

//--- logic/vram_write_port.sv
// single-entry holding register for host VRAM writes
// issues the write in the host slot on the even or odd port

module vram_write_port (
    input  logic clk,
    input  logic rst_n,

    input  video_timing_pkg::raster_x_t raster_x,

    input  vdp_regs_pkg::vram_request_t request,
    input  logic request_valid,
    output logic busy,

    output vdp_regs_pkg::vram_word_addr_t vram_address_even,
    output vdp_regs_pkg::vram_word_addr_t vram_address_odd,
    output vdp_regs_pkg::vram_data_t vram_write_data_even,
    output vdp_regs_pkg::vram_data_t vram_write_data_odd,
    output logic vram_we_even,
    output logic vram_we_odd
);

    typedef enum logic {
        port_idle,
        port_pending
    } port_state_t;

    port_state_t state;
    vdp_regs_pkg::vram_request_t pending;

    logic in_slot;
    logic accept;
    logic issue;

    assign in_slot = (raster_x[2:0] == video_timing_pkg::host_slot_phase);
    assign accept = (state == port_idle) && request_valid;
    assign issue = (state == port_pending) && in_slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= port_idle;
            vram_we_even <= 1'b0;
            vram_we_odd <= 1'b0;
        end else begin
            vram_we_even <= issue && pending.port_mask[0];
            vram_we_odd <= issue && pending.port_mask[1];
            if (accept) begin
                state <= port_pending;
            end else if (issue) begin
                state <= port_idle;
            end
        end
    end

    // address and data hold between slots, no render fetch shares the bus
    always_ff @(posedge clk) begin
        if (accept) begin
            pending <= request;
        end
        if (issue) begin
            vram_address_even <= pending.address;
            vram_address_odd <= pending.address;
            vram_write_data_even <= pending.data;
            vram_write_data_odd <= pending.data;
        end
    end

    assign busy = (state == port_pending);

endmodule

//--- logic/host_registers.sv
// host write decode into the register map
// palette and VRAM write addresses with auto-increment
// raster position readback and raster target compare

module host_registers (
    input  logic clk,
    input  logic rst_n,

    input  vdp_regs_pkg::host_write_t host_write,
    input  logic read_select,

    input  video_timing_pkg::raster_x_t raster_x,
    input  video_timing_pkg::raster_y_t raster_y,

    input  logic vram_busy,

    output vdp_regs_pkg::host_data_t host_read_data,
    output vdp_regs_pkg::palette_write_t palette_write,
    output vdp_regs_pkg::vram_request_t vram_request,
    output logic vram_request_valid,
    output vdp_regs_pkg::layer_enable_t layer_enable,
    output logic target_raster_hit
);

    vdp_regs_pkg::palette_index_t palette_address;
    vdp_regs_pkg::palette_index_t palette_write_index;
    vdp_regs_pkg::host_data_t palette_write_data;
    logic palette_write_enable;

    vdp_regs_pkg::vram_byte_addr_t vram_byte_address;
    logic [7:0] vram_increment;

    video_timing_pkg::raster_x_t target_x;
    video_timing_pkg::raster_y_t target_y;

    logic vram_data_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            palette_address <= '0;
            palette_write_enable <= 1'b0;
            vram_byte_address <= '0;
            vram_increment <= '0;
            layer_enable <= '0;
            target_x <= '0;
            target_y <= '0;
            target_raster_hit <= 1'b0;
        end else begin
            palette_write_enable <= 1'b0;
            target_raster_hit <= (raster_x == target_x) && (raster_y == target_y);

            if (host_write.valid) begin
                case (host_write.address)
                    vdp_regs_pkg::reg_palette_addr: begin
                        palette_address <= host_write.data[7:0];
                    end
                    vdp_regs_pkg::reg_palette_data: begin
                        palette_write_enable <= 1'b1;
                        palette_address <= palette_address + 8'd1;
                    end
                    vdp_regs_pkg::reg_vram_addr: begin
                        vram_byte_address <= host_write.data[14:0];
                    end
                    vdp_regs_pkg::reg_vram_data: begin
                        // the request carries the current address, the next one the advanced
                        vram_byte_address <= vram_byte_address + {7'd0, vram_increment};
                    end
                    vdp_regs_pkg::reg_vram_increment: vram_increment <= host_write.data[7:0];
                    vdp_regs_pkg::reg_layer_enable: layer_enable <= host_write.data[5:0];
                    vdp_regs_pkg::reg_target_x: target_x <= host_write.data[10:0];
                    vdp_regs_pkg::reg_target_y: target_y <= host_write.data[9:0];
                    default: begin
                        // unmapped registers are ignored
                    end
                endcase
            end
        end
    end

    // palette payload, the index is the address before it advances
    always_ff @(posedge clk) begin
        if (host_write.valid && host_write.address == vdp_regs_pkg::reg_palette_data) begin
            palette_write_index <= palette_address;
            palette_write_data <= host_write.data;
        end
    end

    // raster readback, bit 0 of the host address picks x or y
    always_ff @(posedge clk) begin
        host_read_data <= read_select ? vdp_regs_pkg::host_data_t'(raster_y)
                                      : vdp_regs_pkg::host_data_t'(raster_x);
    end

    always_comb begin
        palette_write.index = palette_write_index;
        palette_write.data = palette_write_data;
        palette_write.enable = palette_write_enable;
    end

    // VRAM request goes straight to the write port so busy rises on the next edge
    assign vram_data_write = host_write.valid &&
                             (host_write.address == vdp_regs_pkg::reg_vram_data);
    assign vram_request_valid = vram_data_write && !vram_busy;

    always_comb begin
        vram_request.address = vram_byte_address[14:1];
        vram_request.data = host_write.data;
        vram_request.port_mask = vram_byte_address[0] ? 2'b10 : 2'b01;
    end

endmodule

//--- logic/vga_timing.sv
// raster counters for the 640x480 display
// VGA sync levels, active display flag
// single-cycle line and frame strobes

module vga_timing (
    input  logic clk,
    input  logic rst_n,

    output video_timing_pkg::raster_x_t raster_x,
    output video_timing_pkg::raster_y_t raster_y,

    output logic active_display,
    output logic vga_hsync,
    output logic vga_vsync,

    // strobes, one cycle wide and not for driving a monitor
    output logic hsync,
    output logic vsync,
    output logic active_frame_ended
);

    localparam video_timing_pkg::raster_x_t x_last =
        video_timing_pkg::raster_x_t'(video_timing_pkg::h_total - 1);
    localparam video_timing_pkg::raster_y_t y_last =
        video_timing_pkg::raster_y_t'(video_timing_pkg::v_total - 1);

    // sync pulse windows
    localparam video_timing_pkg::raster_x_t hsync_start =
        video_timing_pkg::raster_x_t'(video_timing_pkg::h_front_porch);
    localparam video_timing_pkg::raster_x_t hsync_end =
        video_timing_pkg::raster_x_t'(video_timing_pkg::h_front_porch +
                                      video_timing_pkg::h_sync);
    localparam video_timing_pkg::raster_y_t vsync_start =
        video_timing_pkg::raster_y_t'(video_timing_pkg::v_active +
                                      video_timing_pkg::v_front_porch);
    localparam video_timing_pkg::raster_y_t vsync_end =
        video_timing_pkg::raster_y_t'(video_timing_pkg::v_active +
                                      video_timing_pkg::v_front_porch +
                                      video_timing_pkg::v_sync);

    logic line_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (line_end) begin
            raster_x <= '0;
            raster_y <= (raster_y == y_last) ? '0 : raster_y + 10'd1;
        end else begin
            raster_x <= raster_x + 11'd1;
        end
    end

    assign line_end = (raster_x == x_last);

    // visible pixels sit after the horizontal blanking
    assign active_display =
        (raster_x >= video_timing_pkg::raster_x_t'(video_timing_pkg::h_offscreen)) &&
        (raster_y < video_timing_pkg::raster_y_t'(video_timing_pkg::v_active));

    // both syncs are active low
    assign vga_hsync = !((raster_x >= hsync_start) && (raster_x < hsync_end));
    assign vga_vsync = !((raster_y >= vsync_start) && (raster_y < vsync_end));

    assign hsync = line_end;
    assign vsync = line_end && (raster_y == y_last);
    assign active_frame_ended = line_end &&
        (raster_y == video_timing_pkg::raster_y_t'(video_timing_pkg::v_active - 1));

endmodule

//--- logic/vdp_regs_pkg.sv
// host register numbers of the register map
// colour, palette and VRAM types
// packed structs for host writes, VRAM requests and palette writes

package vdp_regs_pkg;

    // host port words
    typedef logic [5:0] reg_addr_t;
    typedef logic [15:0] host_data_t;

    // register map
    // palette address and data, then VRAM address, data and increment
    localparam reg_addr_t reg_palette_addr = 6'd2;
    localparam reg_addr_t reg_palette_data = 6'd3;
    localparam reg_addr_t reg_vram_addr = 6'd4;
    localparam reg_addr_t reg_vram_data = 6'd5;
    localparam reg_addr_t reg_vram_increment = 6'd6;

    // display control in the upper register bank
    localparam reg_addr_t reg_layer_enable = 6'd32;
    localparam reg_addr_t reg_target_x = 6'd35;
    localparam reg_addr_t reg_target_y = 6'd36;

    // palette and colour
    typedef logic [7:0] palette_index_t;
    typedef logic [11:0] color_t;

    // with no layers rendered every pixel resolves to the backdrop
    localparam palette_index_t backdrop_index = 8'd0;

    // VRAM is split into an even and an odd 16-bit port
    // the byte address selects the port with bit 0
    typedef logic [14:0] vram_byte_addr_t;
    typedef logic [13:0] vram_word_addr_t;
    typedef logic [15:0] vram_data_t;

    typedef logic [5:0] layer_enable_t;

    // one accepted host write
    typedef struct packed {
        reg_addr_t address;
        host_data_t data;
        logic valid;
    } host_write_t;

    // port_mask bit 0 is the even port, bit 1 the odd port
    typedef struct packed {
        vram_word_addr_t address;
        vram_data_t data;
        logic [1:0] port_mask;
    } vram_request_t;

    typedef struct packed {
        palette_index_t index;
        host_data_t data;
        logic enable;
    } palette_write_t;

endpackage

//--- logic/video_timing_pkg.sv
// raster coordinate types for the display timing
// 640x480 horizontal and vertical timing constants
// phase of the host VRAM write slot within each 8-pixel group

package video_timing_pkg;

    // horizontal position, counts through the whole line
    typedef logic [10:0] raster_x_t;

    // vertical position, counts through the whole frame
    typedef logic [9:0] raster_y_t;

    // horizontal timing in pixels
    // blanking comes first on each line, the visible pixels last
    localparam int h_active = 640;
    localparam int h_front_porch = 16;
    localparam int h_sync = 96;
    localparam int h_back_porch = 48;

    localparam int h_offscreen = h_front_porch + h_sync + h_back_porch;
    localparam int h_total = h_active + h_offscreen;

    // vertical timing in lines
    // visible lines come first, then the blanking interval
    localparam int v_active = 480;
    localparam int v_front_porch = 11;
    localparam int v_sync = 2;
    localparam int v_back_porch = 31;

    localparam int v_total = v_active + v_front_porch + v_sync + v_back_porch;

    // host writes are issued on the edge that ends phase 7
    // so the write enable is seen while raster_x[2:0] is 0
    localparam logic [2:0] host_slot_phase = 3'd7;

endpackage
